// File: hdl/mem_pkg.sv
/* Shared request types and byte-lane helpers for the data memory path.
   Accesses are assumed naturally aligned; no sign extension is done. */
`default_nettype none

package mem_pkg;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // byte count minus one.
  typedef enum logic [2:0] {
    SIZE_B = 3'd0,
    SIZE_H = 3'd1,
    SIZE_W = 3'd3,
    SIZE_D = 3'd7
  } mem_size_e;

  typedef struct packed {
    mem_op_e     op;
    logic [63:0] addr;
    mem_size_e   size;
    logic [63:0] wdata;
  } dcache_req_t;

  typedef struct packed {
    logic        we;
    logic [60:0] word_addr;
    logic [63:0] wdata;
    logic [7:0]  strb;
  } ram_req_t;

  function automatic logic [7:0] size_mask(mem_size_e size);
    case (size)
      SIZE_B:  return 8'h01;
      SIZE_H:  return 8'h03;
      SIZE_W:  return 8'h0f;
      default: return 8'hff;
    endcase
  endfunction

  function automatic logic [7:0] lane_strb(mem_size_e size, logic [2:0] off);
    return size_mask(size) << off;
  endfunction

  function automatic logic [63:0] lane_extract(logic [63:0] dword, logic [2:0] off,
                                               mem_size_e size);
    logic [63:0] shifted;
    logic [7:0]  mask;
    shifted = dword >> {off, 3'b000};
    mask    = size_mask(size);
    for (int b = 0; b < 8; b++) begin
      if (!mask[b]) begin
        shifted[8*b +: 8] = 8'h00;
      end
    end
    return shifted;
  endfunction

endpackage

`default_nettype wire

// File: hdl/mem_access_unit.sv
/* One access in flight at a time; i_start is only legal while idle.
   o_rdata holds the last read result, writes leave it unchanged. */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit
  import mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  logic        i_start,
  input  logic        i_ren,
  input  logic        i_wen,
  input  logic [63:0] i_addr,
  input  mem_size_e   i_size,
  input  logic [63:0] i_wdata,
  input  logic        i_done_ack,
  output logic        o_done,
  output logic [63:0] o_rdata,

  //////////////////////////////
  // dcache side
  output logic        o_dcache_valid,
  output dcache_req_t o_dcache_req,
  input  logic        i_dcache_ack,
  input  logic [63:0] i_dcache_rdata
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DONE
  } state_e;

  state_e      state_q;
  dcache_req_t req_q;
  logic        accept;

  // a strobe without ren or wen is dropped.
  assign accept = (state_q == IDLE) && i_start && (i_ren || i_wen);

  assign o_dcache_valid = (state_q == WAIT);
  assign o_dcache_req   = req_q;
  assign o_done         = (state_q == DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      o_rdata <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (i_dcache_ack) begin
            state_q <= DONE;
            if (req_q.op == MEM_READ) begin
              o_rdata <= i_dcache_rdata;
            end
          end
        end
        DONE: begin
          if (i_done_ack) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // read wins when both enables come with the strobe.
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q.op    <= i_ren ? MEM_READ : MEM_WRITE;
      req_q.addr  <= i_addr;
      req_q.size  <= i_size;
      req_q.wdata <= i_wdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/dcache.sv
/* Direct-mapped, write-through, no-write-allocate; one doubleword per line.
   i_req must stay stable while i_req_valid is high, up to the ack. */
`timescale 1ns/1ps
`default_nettype none

module dcache
  import mem_pkg::*;
#(
  parameter int CACHE_IDX_W = 4
) (
  input  logic        clk,
  input  logic        rst,

  input  logic        i_req_valid,
  input  dcache_req_t i_req,
  output logic        o_ack,
  output logic [63:0] o_rdata,

  //////////////////////////////
  // backing ram side
  output logic        o_ram_valid,
  output ram_req_t    o_ram_req,
  input  logic        i_ram_ack,
  input  logic [63:0] i_ram_rdata
);

  localparam int LINES = 1 << CACHE_IDX_W;
  localparam int TAG_W = 61 - CACHE_IDX_W;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    RAM_WAIT,
    RESPOND
  } state_e;

  state_e state_q;

  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_q  [LINES];
  logic [63:0]      data_q [LINES];

  logic [CACHE_IDX_W-1:0] idx;
  logic [TAG_W-1:0]       tag;
  logic [2:0]             off;
  logic                   is_write;
  logic                   hit;
  logic [63:0]            line;
  logic [7:0]             strb;
  logic [63:0]            lane_wdata;
  logic [63:0]            merged;

  //////////////////////////////
  // address split and lookup
  assign idx      = i_req.addr[3 +: CACHE_IDX_W];
  assign tag      = i_req.addr[63 -: TAG_W];
  assign off      = i_req.addr[2:0];
  assign is_write = (i_req.op == MEM_WRITE);
  assign line     = data_q[idx];
  assign hit      = valid_q[idx] && (tag_q[idx] == tag);

  //////////////////////////////
  // byte lanes
  assign strb       = lane_strb(i_req.size, off);
  assign lane_wdata = i_req.wdata << {off, 3'b000};

  // new bytes over the cached line, for write hits.
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      merged[8*b +: 8] = strb[b] ? lane_wdata[8*b +: 8] : line[8*b +: 8];
    end
  end

  // after a fill the line already holds the new word by RESPOND.
  assign o_rdata = lane_extract(line, off, i_req.size);

  assign o_ack = ((state_q == LOOKUP) && hit && !is_write) || (state_q == RESPOND);

  assign o_ram_valid = (state_q == RAM_WAIT);
  assign o_ram_req   = '{
    we:        is_write,
    word_addr: i_req.addr[63:3],
    wdata:     lane_wdata,
    strb:      strb
  };

  //////////////////////////////
  // sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_req_valid) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          // read hits finish here; all else goes to ram.
          if (hit && !is_write) begin
            state_q <= IDLE;
          end else begin
            state_q <= RAM_WAIT;
          end
        end
        RAM_WAIT: begin
          if (i_ram_ack) begin
            state_q <= RESPOND;
            if (!is_write) begin
              valid_q[idx] <= 1'b1;
            end
          end
        end
        RESPOND: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // fill on read miss, update on write hit; write miss leaves the line.
  always_ff @(posedge clk) begin
    if ((state_q == RAM_WAIT) && i_ram_ack) begin
      if (!is_write) begin
        tag_q[idx]  <= tag;
        data_q[idx] <= i_ram_rdata;
      end else if (hit) begin
        data_q[idx] <= merged;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/backing_ram.sv
/* RAM_WORDS must be a power of two; addresses wrap modulo the depth.
   RAM_LATENCY >= 1. Contents start at zero and survive rst. */
`timescale 1ns/1ps
`default_nettype none

module backing_ram
  import mem_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic        clk,
  input  logic        rst,

  input  logic        i_valid,
  input  ram_req_t    i_req,
  output logic        o_ack,
  output logic [63:0] o_rdata
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  logic [63:0]      mem_q [RAM_WORDS];
  ram_req_t         req_q;
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [IDX_W-1:0] idx;

  assign idx     = req_q.word_addr[IDX_W-1:0];
  assign o_ack   = busy_q && (cnt_q == '0);
  assign o_rdata = mem_q[idx];

  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // latency counter.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      if (i_valid) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(RAM_LATENCY - 1);
      end
    end else if (cnt_q == '0) begin
      busy_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && i_valid) begin
      req_q <= i_req;
    end
  end

  // strobed bytes land in the ack cycle.
  always @(posedge clk) begin
    if (o_ack && req_q.we) begin
      for (int b = 0; b < 8; b++) begin
        if (req_q.strb[b]) begin
          mem_q[idx][8*b +: 8] <= req_q.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/mem_subsys_top.sv
/* Memory stage path: access unit, data cache and ram model.
   Pipeline rules: one access at a time, start only while o_done is low. */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
  import mem_pkg::*;
#(
  parameter int CACHE_IDX_W = 4,
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic        clk,
  input  logic        rst,

  input  logic        i_start,
  input  logic        i_ren,
  input  logic        i_wen,
  input  logic [63:0] i_addr,
  input  mem_size_e   i_size,
  input  logic [63:0] i_wdata,
  input  logic        i_done_ack,
  output logic        o_done,
  output logic [63:0] o_rdata
);

  logic        dcache_valid;
  dcache_req_t dcache_req;
  logic        dcache_ack;
  logic [63:0] dcache_rdata;

  logic        ram_valid;
  ram_req_t    ram_req;
  logic        ram_ack;
  logic [63:0] ram_rdata;

  mem_access_unit u_access (
    .clk            (clk),
    .rst            (rst),
    .i_start        (i_start),
    .i_ren          (i_ren),
    .i_wen          (i_wen),
    .i_addr         (i_addr),
    .i_size         (i_size),
    .i_wdata        (i_wdata),
    .i_done_ack     (i_done_ack),
    .o_done         (o_done),
    .o_rdata        (o_rdata),
    .o_dcache_valid (dcache_valid),
    .o_dcache_req   (dcache_req),
    .i_dcache_ack   (dcache_ack),
    .i_dcache_rdata (dcache_rdata)
  );

  dcache #(
    .CACHE_IDX_W (CACHE_IDX_W)
  ) u_dcache (
    .clk         (clk),
    .rst         (rst),
    .i_req_valid (dcache_valid),
    .i_req       (dcache_req),
    .o_ack       (dcache_ack),
    .o_rdata     (dcache_rdata),
    .o_ram_valid (ram_valid),
    .o_ram_req   (ram_req),
    .i_ram_ack   (ram_ack),
    .i_ram_rdata (ram_rdata)
  );

  backing_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_ram (
    .clk     (clk),
    .rst     (rst),
    .i_valid (ram_valid),
    .i_req   (ram_req),
    .o_ack   (ram_ack),
    .o_rdata (ram_rdata)
  );

endmodule

`default_nettype wire

// File: dv/mem_subsys_sva.sv
/* Handshake and reset properties for the memory path, bound into mem_subsys_top.
   Reads internal cache and ram handshake nets through the bind port list. */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_sva
  import mem_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        i_done,
  input logic        i_done_ack,
  input logic        i_dcache_valid,
  input dcache_req_t i_dcache_req,
  input logic        i_dcache_ack,
  input logic        i_ram_ack
);

  int fail_cnt = 0;

  a_done_low_after_reset: assert property (@(posedge clk) rst |=> !i_done)
    else begin
      $error("o_done high in the cycle after reset");
      fail_cnt++;
    end

  // request held steady until the cache answers.
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    i_dcache_valid && !i_dcache_ack |=> i_dcache_valid && $stable(i_dcache_req))
    else begin
      $error("dcache request dropped or changed before ack");
      fail_cnt++;
    end

  a_dcache_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    i_dcache_ack |=> !i_dcache_ack)
    else begin
      $error("dcache ack longer than one cycle");
      fail_cnt++;
    end

  a_ram_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    i_ram_ack |=> !i_ram_ack)
    else begin
      $error("ram ack longer than one cycle");
      fail_cnt++;
    end

  a_done_hold: assert property (@(posedge clk) disable iff (rst)
    i_done && !i_done_ack |=> i_done)
    else begin
      $error("o_done fell without i_done_ack");
      fail_cnt++;
    end

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (
  .clk            (clk),
  .rst            (rst),
  .i_done         (o_done),
  .i_done_ack     (i_done_ack),
  .i_dcache_valid (dcache_valid),
  .i_dcache_req   (dcache_req),
  .i_dcache_ack   (dcache_ack),
  .i_ram_ack      (ram_ack)
);

`default_nettype wire

// File: dv/tb_mem_subsys.sv
/* Table-driven and random checks against a byte-level model of the memory.
   Random addresses stay inside the RAM depth, so no aliased tags occur. */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int    CACHE_IDX_W = 4;
  localparam int    RAM_WORDS   = 256;
  localparam int    RAM_LATENCY = 3;
  localparam int    RAM_BYTES   = RAM_WORDS * 8;
  localparam int    CLK_PERIOD  = 100;
  localparam int    NUM_VECS    = 33;
  localparam int    NUM_RANDOM  = 200;
  localparam int    DONE_LIMIT  = 4 * (RAM_LATENCY + 8);
  localparam int    NONE_WINDOW = RAM_LATENCY + 8;
  localparam longint WATCHDOG_NS = longint'(NUM_VECS + NUM_RANDOM) * (RAM_LATENCY + 8)
                                   * CLK_PERIOD;

  typedef enum logic [1:0] {
    OP_RD,
    OP_WR,
    OP_RW,
    OP_NONE
  } op_kind_e;

  typedef struct packed {
    op_kind_e    kind;
    logic [63:0] addr;
    mem_size_e   size;
    logic [63:0] wdata;
    logic [63:0] exp;
    logic [3:0]  hold;
  } vec_t;

  logic        clk;
  logic        rst;
  logic        i_start;
  logic        i_ren;
  logic        i_wen;
  logic [63:0] i_addr;
  mem_size_e   i_size;
  logic [63:0] i_wdata;
  logic        i_done_ack;
  logic        o_done;
  logic [63:0] o_rdata;

  logic [7:0] ref_mem [RAM_BYTES];
  vec_t       vecs [NUM_VECS];
  int         n_vecs;
  int         errors;
  integer     seed;

  mem_subsys_top #(
    .CACHE_IDX_W (CACHE_IDX_W),
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .i_ren      (i_ren),
    .i_wen      (i_wen),
    .i_addr     (i_addr),
    .i_size     (i_size),
    .i_wdata    (i_wdata),
    .i_done_ack (i_done_ack),
    .o_done     (o_done),
    .o_rdata    (o_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  always @(negedge clk) begin
    if (u_dut.u_sva.fail_cnt != 0) begin
      $display("a handshake assertion in the bound checker failed");
      $display("Result: FAILED");
      $fatal(1, "assertion failed");
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////
  // byte-level reference model
  function automatic logic [63:0] model_read(input logic [63:0] addr, input mem_size_e size);
    logic [63:0] val;
    val = '0;
    for (int b = 0; b <= int'(size); b++) begin
      val[8*b +: 8] = ref_mem[(addr + 64'(b)) % RAM_BYTES];
    end
    return val;
  endfunction

  task automatic model_write(input logic [63:0] addr, input mem_size_e size,
                             input logic [63:0] wdata);
    for (int b = 0; b <= int'(size); b++) begin
      ref_mem[(addr + 64'(b)) % RAM_BYTES] = wdata[8*b +: 8];
    end
  endtask

  task automatic add_vec(input op_kind_e kind, input logic [63:0] addr, input mem_size_e size,
                         input logic [63:0] wdata, input logic [63:0] exp, input int hold);
    vec_t v;
    v.kind  = kind;
    v.addr  = addr;
    v.size  = size;
    v.wdata = wdata;
    v.exp   = exp;
    v.hold  = 4'(hold);
    vecs[n_vecs] = v;
    n_vecs++;
  endtask

  task automatic load_vectors();
    // fresh memory reads as zero.
    add_vec(OP_RD, 64'h000, SIZE_D, 64'h0, 64'h0, 0);
    add_vec(OP_RD, 64'h7fc, SIZE_W, 64'h0, 64'h0, 0);
    // write miss, then read miss with fill, then read hit.
    add_vec(OP_WR, 64'h100, SIZE_D, 64'h0123_4567_89ab_cdef, 64'h0, 0);
    add_vec(OP_RD, 64'h100, SIZE_D, 64'h0, 64'h0123_4567_89ab_cdef, 0);
    add_vec(OP_RD, 64'h100, SIZE_D, 64'h0, 64'h0123_4567_89ab_cdef, 0);
    // sub-word merges into a cached line.
    add_vec(OP_RD, 64'h200, SIZE_D, 64'h0, 64'h0, 0);
    add_vec(OP_WR, 64'h200, SIZE_B, 64'hffff_ffff_ffff_ffaa, 64'h0, 0);
    add_vec(OP_WR, 64'h201, SIZE_B, 64'h55, 64'h0, 0);
    add_vec(OP_WR, 64'h202, SIZE_H, 64'h1234_beef, 64'h0, 0);
    add_vec(OP_WR, 64'h204, SIZE_W, 64'hdead_c0de, 64'h0, 0);
    add_vec(OP_RD, 64'h200, SIZE_D, 64'h0, 64'hdead_c0de_beef_55aa, 0);
    add_vec(OP_RD, 64'h203, SIZE_B, 64'h0, 64'hbe, 0);
    add_vec(OP_RD, 64'h206, SIZE_H, 64'h0, 64'hdead, 0);
    add_vec(OP_RD, 64'h204, SIZE_W, 64'h0, 64'hdead_c0de, 0);
    add_vec(OP_RD, 64'h202, SIZE_H, 64'h0, 64'hbeef, 0);
    add_vec(OP_RD, 64'h207, SIZE_B, 64'h0, 64'hde, 0);
    add_vec(OP_RD, 64'h200, SIZE_W, 64'h0, 64'hbeef_55aa, 0);
    // 0x040 and 0x440 share index 8 with different tags.
    add_vec(OP_WR, 64'h040, SIZE_D, 64'h1111_2222_3333_4444, 64'h0, 0);
    add_vec(OP_RD, 64'h040, SIZE_D, 64'h0, 64'h1111_2222_3333_4444, 0);
    add_vec(OP_WR, 64'h440, SIZE_D, 64'h5555_6666_7777_8888, 64'h0, 0);
    add_vec(OP_RD, 64'h440, SIZE_D, 64'h0, 64'h5555_6666_7777_8888, 0);
    add_vec(OP_RD, 64'h040, SIZE_D, 64'h0, 64'h1111_2222_3333_4444, 0);
    add_vec(OP_WR, 64'h044, SIZE_W, 64'h9999_aaaa, 64'h0, 0);
    add_vec(OP_RD, 64'h040, SIZE_D, 64'h0, 64'h9999_aaaa_3333_4444, 0);
    add_vec(OP_WR, 64'h440, SIZE_H, 64'hbbbb, 64'h0, 0);
    add_vec(OP_RD, 64'h440, SIZE_D, 64'h0, 64'h5555_6666_7777_bbbb, 0);
    // refill from ram after the write hit on 0x044.
    add_vec(OP_RD, 64'h040, SIZE_D, 64'h0, 64'h9999_aaaa_3333_4444, 0);
    // late done ack, a dropped strobe, read priority.
    add_vec(OP_RD, 64'h200, SIZE_D, 64'h0, 64'hdead_c0de_beef_55aa, 5);
    add_vec(OP_WR, 64'h300, SIZE_D, 64'h0f0e_0d0c_0b0a_0908, 64'h0, 4);
    add_vec(OP_NONE, 64'h300, SIZE_D, 64'h0, 64'h0, 0);
    add_vec(OP_RD, 64'h306, SIZE_H, 64'h0, 64'h0f0e, 0);
    add_vec(OP_RW, 64'h300, SIZE_D, 64'hffff_ffff_ffff_ffff, 64'h0f0e_0d0c_0b0a_0908, 0);
    add_vec(OP_RD, 64'h300, SIZE_D, 64'h0, 64'h0f0e_0d0c_0b0a_0908, 0);
  endtask

  //////////////////////////////
  // pipeline-side driver
  task automatic run_access(input op_kind_e kind, input logic [63:0] addr,
                            input mem_size_e size, input logic [63:0] wdata,
                            input int hold, output logic [63:0] rdata);
    int          waited;
    logic [63:0] held;
    waited     = 0;
    i_start    = 1'b1;
    i_ren      = (kind == OP_RD) || (kind == OP_RW);
    i_wen      = (kind == OP_WR) || (kind == OP_RW);
    i_addr     = addr;
    i_size     = size;
    i_wdata    = wdata;
    @(negedge clk);
    i_start = 1'b0;
    i_ren   = 1'b0;
    i_wen   = 1'b0;
    while (!o_done) begin
      if (waited == DONE_LIMIT) begin
        $display("timeout: no o_done %0d cycles after start at address 0x%h", waited, addr);
        $display("Result: FAILED");
        $fatal(1, "access never finished");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    held = o_rdata;
    // done and data must sit still while the ack is late.
    for (int c = 0; c < hold; c++) begin
      @(negedge clk);
      check("o_done", o_done, 64'h1);
      check("o_rdata", o_rdata, held);
    end
    i_done_ack = 1'b1;
    @(negedge clk);
    i_done_ack = 1'b0;
    check("o_done", o_done, 64'h0);
    rdata = held;
  endtask

  task automatic ignored_start(input logic [63:0] addr);
    i_start = 1'b1;
    i_addr  = addr;
    @(negedge clk);
    i_start = 1'b0;
    repeat (NONE_WINDOW) begin
      check("o_done", o_done, 64'h0);
      @(negedge clk);
    end
  endtask

  task automatic apply_vector(input vec_t v);
    logic [63:0] rd;
    if (v.kind == OP_NONE) begin
      ignored_start(v.addr);
    end else begin
      run_access(v.kind, v.addr, v.size, v.wdata, int'(v.hold), rd);
      if (v.kind == OP_WR) begin
        model_write(v.addr, v.size, v.wdata);
      end else begin
        check("ref_model", model_read(v.addr, v.size), v.exp);
        check("o_rdata", rd, v.exp);
      end
    end
  endtask

  task automatic run_random();
    integer      r;
    op_kind_e    kind;
    mem_size_e   size;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [63:0] rd;
    int          hold;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r    = $random(seed);
      kind = r[0] ? OP_WR : OP_RD;
      case (r[2:1])
        2'd0:    size = SIZE_B;
        2'd1:    size = SIZE_H;
        2'd2:    size = SIZE_W;
        default: size = SIZE_D;
      endcase
      hold  = (r[4:3] == 2'b11) ? 3 : 0;
      addr  = {40'd0, r[31:8]} & 64'(RAM_BYTES - 1);
      addr  = addr & ~{61'd0, size};
      wdata = {$random(seed), $random(seed)};
      run_access(kind, addr, size, wdata, hold, rd);
      if (kind == OP_WR) begin
        model_write(addr, size, wdata);
      end else begin
        check("o_rdata", rd, model_read(addr, size));
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    i_start    = 1'b0;
    i_ren      = 1'b0;
    i_wen      = 1'b0;
    i_addr     = '0;
    i_size     = SIZE_B;
    i_wdata    = '0;
    i_done_ack = 1'b0;
    errors     = 0;
    n_vecs     = 0;
    seed       = 32'h5d0c_5f8c;
    for (int i = 0; i < RAM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    load_vectors();
    if (n_vecs != NUM_VECS) begin
      $display("vector table holds %0d entries instead of %0d", n_vecs, NUM_VECS);
      $display("Result: FAILED");
      $fatal(1, "bad vector table");
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("o_done", o_done, 64'h0);
    check("o_rdata", o_rdata, 64'h0);
    for (int i = 0; i < NUM_VECS; i++) begin
      apply_vector(vecs[i]);
    end
    run_random();
    if (errors == 0 && u_dut.u_sva.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/mem_pkg.sv
hdl/mem_access_unit.sv
hdl/dcache.sv
hdl/backing_ram.sv
hdl/mem_subsys_top.sv
dv/mem_subsys_sva.sv
dv/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/mem_access_unit.sv
      - hdl/dcache.sv
      - hdl/backing_ram.sv
      - hdl/mem_subsys_top.sv
  - target: test
    files:
      - dv/mem_subsys_sva.sv
      - dv/tb_mem_subsys.sv
